/* compile.f */
hw/video_pkg.sv
hw/pix_stream_if.sv
hw/sync_edge_front.sv
hw/frame_event_gen.sv
hw/channel_stats.sv
hw/frame_stats_collect.sv
hw/video_stats_top.sv
verif/tb_video_stats.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the video statistics testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_video_stats \
  -Mdir obj_dir \
  -o sim_video_stats \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_video_stats > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi

echo "pass message not found in sim.log"
exit 1

/* verif/tb_video_stats.sv */
// self-checking testbench for video_stats_top that runs as the simulation top from compile.f
`timescale 1ns/1ps

module tb_video_stats;

  // ----------------------------------------------------------
  // constants and stimulus table
  // ----------------------------------------------------------
  localparam int NUM_TESTS    = 7;
  // cycles from the first vs low cycle to frame_done_o
  localparam int DONE_LATENCY = 5;
  localparam int DONE_TIMEOUT = 100;
  // frame gaps this long open with a burst of stray pixels
  localparam int STRAY_GAP    = 6;

  typedef enum logic {
    PAT_CONST,
    PAT_LCG
  } pattern_e;

  // line_gap is the de-low lead-in before every line
  typedef struct packed {
    logic [15:0] width;
    logic [15:0] height;
    logic [7:0]  line_gap;
    logic [7:0]  frame_gap;
    pattern_e    kind;
    logic [23:0] value;
  } frame_cfg_t;

  // reference result of one frame
  typedef struct packed {
    logic [31:0] sum_r;
    logic [31:0] sum_g;
    logic [31:0] sum_b;
    logic [7:0]  max_r;
    logic [7:0]  max_g;
    logic [7:0]  max_b;
    logic [31:0] pix_count;
    logic [31:0] line_count;
    logic [31:0] vs_low_cycle;
  } frame_exp_t;

  // frame gap of 1 means the next frame starts right behind
  frame_cfg_t tests [NUM_TESTS] = '{
    '{16'd4,  16'd3,  8'd2, 8'd8,  PAT_CONST, 24'h102030},
    '{16'd8,  16'd5,  8'd3, 8'd1,  PAT_LCG,   24'h000000},
    '{16'd16, 16'd4,  8'd1, 8'd1,  PAT_LCG,   24'h000000},
    '{16'd5,  16'd9,  8'd2, 8'd10, PAT_LCG,   24'h000000},
    '{16'd1,  16'd1,  8'd1, 8'd7,  PAT_LCG,   24'h000000},
    '{16'd40, 16'd12, 8'd4, 8'd12, PAT_LCG,   24'h000000},
    '{16'd3,  16'd2,  8'd1, 8'd6,  PAT_CONST, 24'h00ff7f}
  };

  string test_names [NUM_TESTS] = '{
    "const_4x3", "rand_8x5_b2b", "rand_16x4_b2b", "rand_5x9",
    "rand_1x1", "rand_40x12", "const_3x2"
  };

  // ----------------------------------------------------------
  // dut and clock
  // ----------------------------------------------------------
  logic                            clk;
  logic                            rst;
  logic                            vs;
  logic                            de;
  logic [video_pkg::RGB_W-1:0]     rgb;
  logic                            frame_done;
  logic [video_pkg::PIX_CNT_W-1:0] pix_count;
  logic [video_pkg::Y_W-1:0]       line_count;
  logic [video_pkg::SUM_W-1:0]     sum_r;
  logic [video_pkg::SUM_W-1:0]     sum_g;
  logic [video_pkg::SUM_W-1:0]     sum_b;
  logic [video_pkg::CH_W-1:0]      max_r;
  logic [video_pkg::CH_W-1:0]      max_g;
  logic [video_pkg::CH_W-1:0]      max_b;

  int          cycle_cnt = 0;
  int          done_seen = 0;
  logic [31:0] lcg_state;
  frame_exp_t  exp_q [$];
  string       exp_name_q [$];

  video_stats_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .vs_i         (vs),
    .de_i         (de),
    .rgb_i        (rgb),
    .frame_done_o (frame_done),
    .pix_count_o  (pix_count),
    .line_count_o (line_count),
    .sum_r_o      (sum_r),
    .sum_g_o      (sum_g),
    .sum_b_o      (sum_b),
    .max_r_o      (max_r),
    .max_g_o      (max_g),
    .max_b_o      (max_b)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // rising edges since time zero for the done latency
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: test %s, %s expected 0x%0h actual 0x%0h",
               test_name, field, expected, actual);
      $display("** FAIL **");
      $fatal(1, "result mismatch");
    end
  endtask

  // called 1 ns after an edge and holds the values until 1 ns after the next one
  task automatic apply_inputs(input logic vs_v, input logic de_v,
                              input logic [video_pkg::RGB_W-1:0] rgb_v);
    vs  = vs_v;
    de  = de_v;
    rgb = rgb_v;
    @(posedge clk);
    #1;
  endtask

  // quiet inputs while the outputs stay at their reset values
  task automatic expect_idle_outputs(input string test_name, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      apply_inputs(1'b0, 1'b0, '0);
      check_value(test_name, "frame_done", 32'd0, 32'(frame_done));
      check_value(test_name, "sums", 32'd0, sum_r | sum_g | sum_b);
      check_value(test_name, "maxima", 32'd0, 32'({max_r, max_g, max_b}));
      check_value(test_name, "counts", 32'd0, 32'(pix_count) | 32'(line_count));
    end
  endtask

  // full-scale de pulse while vs is low so any leak shows up
  task automatic drive_stray_pixels();
    repeat (3) apply_inputs(1'b0, 1'b1, '1);
    apply_inputs(1'b0, 1'b0, '0);
  endtask

  // one frame of the table plus its trailing vs-low gap
  task automatic drive_frame(input int idx);
    frame_cfg_t                  cfg;
    frame_exp_t                  e;
    logic [video_pkg::RGB_W-1:0] pix;
    cfg = tests[idx];
    e   = '0;
    for (int l = 0; l < int'(cfg.height); l++) begin
      repeat (int'(cfg.line_gap)) apply_inputs(1'b1, 1'b0, '0);
      for (int p = 0; p < int'(cfg.width); p++) begin
        if (cfg.kind == PAT_LCG) begin
          lcg_state = lcg_step(lcg_state);
          pix       = lcg_state[31:8];
        end else begin
          pix = cfg.value;
        end
        // reference model with r in the top byte
        e.sum_r = e.sum_r + 32'(pix[23:16]);
        e.sum_g = e.sum_g + 32'(pix[15:8]);
        e.sum_b = e.sum_b + 32'(pix[7:0]);
        if (pix[23:16] > e.max_r) begin
          e.max_r = pix[23:16];
        end
        if (pix[15:8] > e.max_g) begin
          e.max_g = pix[15:8];
        end
        if (pix[7:0] > e.max_b) begin
          e.max_b = pix[7:0];
        end
        apply_inputs(1'b1, 1'b1, pix);
      end
    end
    e.pix_count    = 32'(cfg.width) * 32'(cfg.height);
    e.line_count   = 32'(cfg.height);
    // with strays the last line closes one cycle before vs falls
    if (int'(cfg.frame_gap) >= STRAY_GAP) begin
      apply_inputs(1'b1, 1'b0, '0);
    end
    // the next applied cycle is the first with vs low
    e.vs_low_cycle = 32'(cycle_cnt);
    exp_q.push_back(e);
    exp_name_q.push_back(test_names[idx]);
    if (int'(cfg.frame_gap) >= STRAY_GAP) begin
      // the first stray pixel lands in the eof cycle
      drive_stray_pixels();
      repeat (int'(cfg.frame_gap) - 4) apply_inputs(1'b0, 1'b0, '0);
    end else begin
      repeat (int'(cfg.frame_gap)) apply_inputs(1'b0, 1'b0, '0);
    end
  endtask

  // idle cycles until count results arrived
  task automatic wait_results(input int count);
    int waited;
    waited = 0;
    while (done_seen < count) begin
      if (waited >= DONE_TIMEOUT) begin
        $display("timeout: only %0d of %0d frame results arrived", done_seen, count);
        $display("** FAIL **");
        $fatal(1, "timeout");
      end else begin
        apply_inputs(1'b0, 1'b0, '0);
        waited++;
      end
    end
  endtask

  // ----------------------------------------------------------
  // result monitor sampling on the falling edge
  // ----------------------------------------------------------
  always @(negedge clk) begin : result_monitor
    frame_exp_t e;
    string      n;
    if (!rst && frame_done) begin
      if (exp_q.size() == 0) begin
        $display("frame_done_o pulsed with no frame outstanding");
        $display("** FAIL **");
        $fatal(1, "unexpected done");
      end else begin
        e = exp_q.pop_front();
        n = exp_name_q.pop_front();
        check_value(n, "sum_r", e.sum_r, sum_r);
        check_value(n, "sum_g", e.sum_g, sum_g);
        check_value(n, "sum_b", e.sum_b, sum_b);
        check_value(n, "max_r", 32'(e.max_r), 32'(max_r));
        check_value(n, "max_g", 32'(e.max_g), 32'(max_g));
        check_value(n, "max_b", 32'(e.max_b), 32'(max_b));
        check_value(n, "pix_count", e.pix_count, 32'(pix_count));
        check_value(n, "line_count", e.line_count, 32'(line_count));
        check_value(n, "done_latency", 32'(DONE_LATENCY), 32'(cycle_cnt) - e.vs_low_cycle);
        done_seen <= done_seen + 1;
      end
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    vs        = 1'b0;
    de        = 1'b0;
    rgb       = '0;
    lcg_state = 32'd5;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    expect_idle_outputs("reset_idle", 20);
    // pixels before any vsync are ignored
    drive_stray_pixels();
    expect_idle_outputs("stray_before_frame", 12);
    for (int i = 0; i < NUM_TESTS; i++) begin
      drive_frame(i);
      // back-to-back frames are collected after the next frame
      if (int'(tests[i].frame_gap) > DONE_LATENCY) begin
        wait_results(i + 1);
      end
    end
    wait_results(NUM_TESTS);
    // a late extra done would be caught by the monitor here
    repeat (10) apply_inputs(1'b0, 1'b0, '0);
    if (done_seen == NUM_TESTS && exp_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("result count wrong: %0d results, %0d pending", done_seen, exp_q.size());
      $display("** FAIL **");
      $fatal(1, "result count");
    end
  end

endmodule

/* hw/video_stats_top.sv */
// top level of the per-frame rgb statistics design, raw sync and pixel in, results out
`timescale 1ns/1ps

module video_stats_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            vs_i,
  input  logic                            de_i,
  input  logic [video_pkg::RGB_W-1:0]     rgb_i,
  output logic                            frame_done_o,
  output logic [video_pkg::PIX_CNT_W-1:0] pix_count_o,
  output logic [video_pkg::Y_W-1:0]       line_count_o,
  output logic [video_pkg::SUM_W-1:0]     sum_r_o,
  output logic [video_pkg::SUM_W-1:0]     sum_g_o,
  output logic [video_pkg::SUM_W-1:0]     sum_b_o,
  output logic [video_pkg::CH_W-1:0]      max_r_o,
  output logic [video_pkg::CH_W-1:0]      max_g_o,
  output logic [video_pkg::CH_W-1:0]      max_b_o
);

  // ----------------------------------------------------------
  // front end to event generator
  // ----------------------------------------------------------
  logic                        vs_rise;
  logic                        vs_fall;
  logic                        de_rise;
  logic                        de_fall;
  logic                        in_frame;
  logic                        fe_valid;
  logic [video_pkg::RGB_W-1:0] fe_rgb;
  logic [video_pkg::X_W-1:0]   fe_x;
  logic [video_pkg::Y_W-1:0]   fe_y;

  // lane results into the collector
  logic [video_pkg::SUM_W-1:0] lane_sum [video_pkg::NUM_CH];
  logic [video_pkg::CH_W-1:0]  lane_max [video_pkg::NUM_CH];

  pix_stream_if pix ();

  sync_edge_front u_front (
    .clk         (clk),
    .rst         (rst),
    .vs_i        (vs_i),
    .de_i        (de_i),
    .rgb_i       (rgb_i),
    .vs_rise_o   (vs_rise),
    .vs_fall_o   (vs_fall),
    .de_rise_o   (de_rise),
    .de_fall_o   (de_fall),
    .in_frame_o  (in_frame),
    .pix_valid_o (fe_valid),
    .rgb_o       (fe_rgb),
    .x_o         (fe_x),
    .y_o         (fe_y)
  );

  frame_event_gen #(
    .USE_VS_FALL   (video_pkg::EVT_USE_VS_FALL),
    .GATE_BY_FRAME (video_pkg::EVT_GATE_BY_FRAME)
  ) u_evt (
    .clk         (clk),
    .rst         (rst),
    .vs_rise_i   (vs_rise),
    .vs_fall_i   (vs_fall),
    .de_rise_i   (de_rise),
    .de_fall_i   (de_fall),
    .in_frame_i  (in_frame),
    .pix_valid_i (fe_valid),
    .rgb_i       (fe_rgb),
    .x_i         (fe_x),
    .y_i         (fe_y),
    .out         (pix)
  );

  // ----------------------------------------------------------
  // one lane per colour, lane index picks the byte
  // ----------------------------------------------------------
  for (genvar i = 0; i < video_pkg::NUM_CH; i++) begin : g_lane
    channel_stats u_lane (
      .clk   (clk),
      .rst   (rst),
      .ch_i  (video_pkg::channel_e'(i)),
      .in    (pix),
      .sum_o (lane_sum[i]),
      .max_o (lane_max[i])
    );
  end

  frame_stats_collect u_collect (
    .clk          (clk),
    .rst          (rst),
    .in           (pix),
    .sum_i        (lane_sum),
    .max_i        (lane_max),
    .frame_done_o (frame_done_o),
    .pix_count_o  (pix_count_o),
    .line_count_o (line_count_o),
    .sum_r_o      (sum_r_o),
    .sum_g_o      (sum_g_o),
    .sum_b_o      (sum_b_o),
    .max_r_o      (max_r_o),
    .max_g_o      (max_g_o),
    .max_b_o      (max_b_o)
  );

endmodule

/* hw/frame_stats_collect.sv */
// collector that drains the lanes at frame end and publishes one result with a done pulse
`timescale 1ns/1ps

module frame_stats_collect (
  input  logic                            clk,
  input  logic                            rst,
  pix_stream_if.sink                      in,
  input  logic [video_pkg::SUM_W-1:0]     sum_i [video_pkg::NUM_CH],
  input  logic [video_pkg::CH_W-1:0]      max_i [video_pkg::NUM_CH],
  output logic                            frame_done_o,
  output logic [video_pkg::PIX_CNT_W-1:0] pix_count_o,
  output logic [video_pkg::Y_W-1:0]       line_count_o,
  output logic [video_pkg::SUM_W-1:0]     sum_r_o,
  output logic [video_pkg::SUM_W-1:0]     sum_g_o,
  output logic [video_pkg::SUM_W-1:0]     sum_b_o,
  output logic [video_pkg::CH_W-1:0]      max_r_o,
  output logic [video_pkg::CH_W-1:0]      max_g_o,
  output logic [video_pkg::CH_W-1:0]      max_b_o
);

  video_pkg::stats_state_e        state_q;
  logic [video_pkg::PIX_CNT_W-1:0] pix_cnt;
  logic [video_pkg::Y_W-1:0]       line_cnt;

  // ----------------------------------------------------------
  // fsm and per-frame counters
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= video_pkg::ST_IDLE;
      pix_cnt      <= '0;
      line_cnt     <= '0;
      frame_done_o <= 1'b0;
      pix_count_o  <= '0;
      line_count_o <= '0;
      sum_r_o      <= '0;
      sum_g_o      <= '0;
      sum_b_o      <= '0;
      max_r_o      <= '0;
      max_g_o      <= '0;
      max_b_o      <= '0;
    end else begin
      frame_done_o <= 1'b0;
      case (state_q)
        video_pkg::ST_IDLE: begin
          if (in.sof) begin
            state_q <= video_pkg::ST_ACTIVE;
          end
        end
        video_pkg::ST_ACTIVE: begin
          if (in.eof) begin
            state_q <= video_pkg::ST_PUBLISH;
          end
        end
        video_pkg::ST_PUBLISH: begin
          // lane outputs were latched on eof and are stable now
          pix_count_o  <= pix_cnt;
          line_count_o <= line_cnt;
          sum_r_o      <= sum_i[video_pkg::CH_R];
          sum_g_o      <= sum_i[video_pkg::CH_G];
          sum_b_o      <= sum_i[video_pkg::CH_B];
          max_r_o      <= max_i[video_pkg::CH_R];
          max_g_o      <= max_i[video_pkg::CH_G];
          max_b_o      <= max_i[video_pkg::CH_B];
          frame_done_o <= 1'b1;
          // a one-cycle frame gap puts the next sof right here
          state_q <= in.sof ? video_pkg::ST_ACTIVE : video_pkg::ST_IDLE;
        end
        default: begin
          state_q <= video_pkg::ST_IDLE;
        end
      endcase
      // counting, the pixel under eof lies outside the frame
      if (in.sof) begin
        pix_cnt  <= in.valid ? video_pkg::PIX_CNT_W'(1) : '0;
        line_cnt <= '0;
      end else if (state_q == video_pkg::ST_ACTIVE) begin
        if (in.valid && !in.eof) begin
          pix_cnt <= pix_cnt + 1'b1;
        end
        // the last line may close in the eof cycle
        if (in.eol) begin
          line_cnt <= line_cnt + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // one result per frame
  a_done_single: assert property (
    @(posedge clk) disable iff (rst) frame_done_o |=> !frame_done_o
  );

  // front end coordinates agree with the event stream at each line start
  a_line_start_coords: assert property (
    @(posedge clk) disable iff (rst)
      in.sol |-> (in.x == '0) && (in.sof || in.y == line_cnt)
  );

endmodule

/* hw/channel_stats.sv */
// one colour lane that accumulates the channel sum and maximum over a frame
`timescale 1ns/1ps

module channel_stats (
  input  logic                        clk,
  input  logic                        rst,
  input  video_pkg::channel_e         ch_i,
  pix_stream_if.sink                  in,
  output logic [video_pkg::SUM_W-1:0] sum_o,
  output logic [video_pkg::CH_W-1:0]  max_o
);

  logic [video_pkg::CH_W-1:0]  pix_ch;
  logic [video_pkg::SUM_W-1:0] sum_q;
  logic [video_pkg::CH_W-1:0]  max_q;
  logic                        open_q;

  // r sits in the top byte, so lane 0 takes the highest slice
  assign pix_ch = in.rgb[video_pkg::CH_W * (video_pkg::NUM_CH - 1 - int'(ch_i)) +:
                         video_pkg::CH_W];

  // ----------------------------------------------------------
  // frame window
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      open_q <= 1'b0;
    end else if (in.sof) begin
      open_q <= 1'b1;
    end else if (in.eof) begin
      open_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // running sum and maximum
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (in.sof) begin
      // fresh frame, the first pixel may arrive with sof
      sum_q <= in.valid ? video_pkg::SUM_W'(pix_ch) : '0;
      max_q <= in.valid ? pix_ch : '0;
    end else if (open_q && in.valid && !in.eof) begin
      sum_q <= sum_q + video_pkg::SUM_W'(pix_ch);
      if (pix_ch > max_q) begin
        max_q <= pix_ch;
      end
    end
  end

  // ----------------------------------------------------------
  // held results, replaced at each frame end
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      sum_o <= '0;
      max_o <= '0;
    end else if (in.eof) begin
      sum_o <= sum_q;
      max_o <= max_q;
    end
  end

endmodule

/* hw/frame_event_gen.sv */
// event generator that registers sof/sol/eol/eof pulses and forwards the pixel bus
`timescale 1ns/1ps

module frame_event_gen #(
  // 1: eof from vs_fall, 0: eof from the next vs_rise
  parameter bit USE_VS_FALL   = video_pkg::EVT_USE_VS_FALL,
  // 1: sol/eol only while in_frame is high
  parameter bit GATE_BY_FRAME = video_pkg::EVT_GATE_BY_FRAME
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        vs_rise_i,
  input  logic                        vs_fall_i,
  input  logic                        de_rise_i,
  input  logic                        de_fall_i,
  input  logic                        in_frame_i,
  input  logic                        pix_valid_i,
  input  logic [video_pkg::RGB_W-1:0] rgb_i,
  input  logic [video_pkg::X_W-1:0]   x_i,
  input  logic [video_pkg::Y_W-1:0]   y_i,
  pix_stream_if.src                   out
);

  logic frame_seen;
  logic sof_n;
  logic sol_n;
  logic eol_n;
  logic eof_n;

  // ----------------------------------------------------------
  // forwarded pixel bus
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= pix_valid_i;
    end
  end

  // rgb only moves on valid pixels so blanking stays quiet
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      out.rgb <= rgb_i;
    end
    out.x <= x_i;
    out.y <= y_i;
  end

  // ----------------------------------------------------------
  // open-frame tracking for the inferred eof
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_seen <= 1'b0;
    end else if (vs_rise_i) begin
      frame_seen <= 1'b1;
    end else if (USE_VS_FALL && vs_fall_i) begin
      frame_seen <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // next-cycle events
  // ----------------------------------------------------------
  always_comb begin
    sof_n = vs_rise_i;
    // line edges, optionally restricted to the frame window
    if (GATE_BY_FRAME) begin
      sol_n = de_rise_i & in_frame_i;
      eol_n = de_fall_i & in_frame_i;
    end else begin
      sol_n = de_rise_i;
      eol_n = de_fall_i;
    end
    // without vs_fall the next frame start closes the previous one
    if (USE_VS_FALL) begin
      eof_n = vs_fall_i;
    end else begin
      eof_n = vs_rise_i & frame_seen;
    end
  end

  // registered single-cycle pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      out.sof <= 1'b0;
      out.sol <= 1'b0;
      out.eol <= 1'b0;
      out.eof <= 1'b0;
    end else begin
      out.sof <= sof_n;
      out.sol <= sol_n;
      out.eol <= eol_n;
      out.eof <= eof_n;
    end
  end

  // a line cannot start and end in the same cycle
  a_sol_eol_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(out.sol && out.eol)
  );

endmodule

/* hw/sync_edge_front.sv */
// front end that samples raw vsync/de/rgb and produces edge pulses, x/y and in_frame
`timescale 1ns/1ps

module sync_edge_front (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        vs_i,
  input  logic                        de_i,
  input  logic [video_pkg::RGB_W-1:0] rgb_i,
  output logic                        vs_rise_o,
  output logic                        vs_fall_o,
  output logic                        de_rise_o,
  output logic                        de_fall_o,
  output logic                        in_frame_o,
  output logic                        pix_valid_o,
  output logic [video_pkg::RGB_W-1:0] rgb_o,
  output logic [video_pkg::X_W-1:0]   x_o,
  output logic [video_pkg::Y_W-1:0]   y_o
);

  // ----------------------------------------------------------
  // stage 1, raw input sampling
  // ----------------------------------------------------------
  logic                        vs_q;
  logic                        vs_qq;
  logic                        de_q;
  logic                        de_qq;
  logic [video_pkg::RGB_W-1:0] rgb_q;
  logic                        vs_rise_n;
  logic                        vs_fall_n;
  logic                        de_rise_n;
  logic                        de_fall_n;

  // current and previous sync levels
  always_ff @(posedge clk) begin
    if (rst) begin
      vs_q  <= 1'b0;
      vs_qq <= 1'b0;
      de_q  <= 1'b0;
      de_qq <= 1'b0;
    end else begin
      vs_q  <= vs_i;
      vs_qq <= vs_q;
      de_q  <= de_i;
      de_qq <= de_q;
    end
  end

  always_ff @(posedge clk) begin
    rgb_q <= rgb_i;
  end

  // edges from the sampled levels
  assign vs_rise_n = vs_q & ~vs_qq;
  assign vs_fall_n = ~vs_q & vs_qq;
  assign de_rise_n = de_q & ~de_qq;
  assign de_fall_n = ~de_q & de_qq;

  // ----------------------------------------------------------
  // stage 2, edge pulses, counters and frame level
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      vs_rise_o   <= 1'b0;
      vs_fall_o   <= 1'b0;
      de_rise_o   <= 1'b0;
      de_fall_o   <= 1'b0;
      in_frame_o  <= 1'b0;
      pix_valid_o <= 1'b0;
      x_o         <= '0;
      y_o         <= '0;
    end else begin
      vs_rise_o   <= vs_rise_n;
      vs_fall_o   <= vs_fall_n;
      de_rise_o   <= de_rise_n;
      de_fall_o   <= de_fall_n;
      pix_valid_o <= de_q;
      // high with the vs_rise pulse, drops the cycle after vs_fall
      in_frame_o  <= vs_rise_n | (in_frame_o & ~vs_fall_o);
      // x restarts at each line, steps on every further pixel
      if (de_rise_n) begin
        x_o <= '0;
      end else if (de_q) begin
        x_o <= x_o + 1'b1;
      end
      // y restarts at the frame, steps once a line has ended
      if (vs_rise_n) begin
        y_o <= '0;
      end else if (de_fall_n) begin
        y_o <= y_o + 1'b1;
      end
    end
  end

  // pixel payload, no reset
  always_ff @(posedge clk) begin
    rgb_o <= rgb_q;
  end

  // a frame edge is either an open or a close, never both
  a_vs_edges_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(vs_rise_o && vs_fall_o)
  );

endmodule

/* hw/pix_stream_if.sv */
// forwarded pixel bus with frame/line event pulses, driven by the event generator
`timescale 1ns/1ps

interface pix_stream_if;

  // pixel qualifier, high on active pixels
  logic                        valid;
  // pixel value, held between valid cycles
  logic [video_pkg::RGB_W-1:0] rgb;
  // pixel index within the line
  logic [video_pkg::X_W-1:0]   x;
  // line index within the frame
  logic [video_pkg::Y_W-1:0]   y;

  // single-cycle event pulses
  logic                        sof;
  logic                        sol;
  logic                        eol;
  logic                        eof;

  // event generator side
  modport src (
    output valid,
    output rgb,
    output x,
    output y,
    output sof,
    output sol,
    output eol,
    output eof
  );

  // statistics lanes and collector
  modport sink (
    input valid,
    input rgb,
    input x,
    input y,
    input sof,
    input sol,
    input eol,
    input eof
  );

endinterface

/* hw/video_pkg.sv */
// shared widths, limits, enums and event defaults for the video statistics design
package video_pkg;

  // ----------------------------------------------------------
  // pixel bus
  // ----------------------------------------------------------
  // full rgb word, r in the top byte
  localparam int RGB_W  = 24;
  // one colour channel
  localparam int CH_W   = 8;
  // number of colour lanes
  localparam int NUM_CH = 3;

  // ----------------------------------------------------------
  // coordinates and counters
  // ----------------------------------------------------------
  // up to 2047 pixels per line
  localparam int X_W = 11;
  // up to 1023 lines per frame
  localparam int Y_W = 10;
  // per-frame channel sum, 2047 x 1023 x 255 fits
  localparam int SUM_W = 32;
  // pixels per frame, width x height
  localparam int PIX_CNT_W = X_W + Y_W;

  // ----------------------------------------------------------
  // frame_event_gen configuration used by the top
  // ----------------------------------------------------------
  // eof from an explicit vsync fall
  localparam bit EVT_USE_VS_FALL   = 1'b1;
  // sol/eol only inside the frame window
  localparam bit EVT_GATE_BY_FRAME = 1'b1;

  // lane index, also selects the byte of the rgb word
  typedef enum logic [1:0] {
    CH_R = 2'd0,
    CH_G = 2'd1,
    CH_B = 2'd2
  } channel_e;

  // collector fsm
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ACTIVE  = 2'd1,
    ST_PUBLISH = 2'd2
  } stats_state_e;

endpackage
